//--- Bender.yml
package:
  name: wdma_dat_out

sources:
  - include_dirs:
      - design
    files:
      - design/wdma_cfg_pkg.sv
      - design/wdma_pkt_pkg.sv
      - design/wdma_cmd_latch.sv
      - design/wdma_beat_sequencer.sv
      - design/wdma_req_packer.sv
      - design/wdma_eq_status.sv
      - design/wdma_dat_out.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/wdma_clk_gen.sv
      - tests/wdma_dat_out_tb.sv

//--- all.f
+incdir+design
design/wdma_cfg_pkg.sv
design/wdma_pkt_pkg.sv
design/wdma_cmd_latch.sv
design/wdma_beat_sequencer.sv
design/wdma_req_packer.sv
design/wdma_eq_status.sv
design/wdma_dat_out.sv
tests/wdma_clk_gen.sv
tests/wdma_dat_out_tb.sv

//--- design/wdma_beat_sequencer.sv
// write dma beat sequencer
`timescale 1ns/1ps
`default_nettype none

`include "wdma_defines.svh"

module wdma_beat_sequencer import wdma_pkt_pkg::*; (
  input  logic                   autosa_core_clk,
  input  logic                   autosa_core_rstn,
  // held command
  input  logic                   cmd_held,
  input  wdma_cmd_t              cmd,
  // request port ready, forced high in quiet mode
  input  logic                   dma_rdy,
  // data fifo handshake
  input  logic [`WDMA_LANES-1:0] dfifo_rd_pvld,
  output logic [`WDMA_LANES-1:0] dfifo_rd_prdy,
  // to the packer
  output logic                   cmd_phase,
  output logic [`WDMA_LANES-1:0] lane_sel,
  output logic                   beat_vld,
  // to the status logic and the latch
  output logic [`WDMA_LANES-1:0] lane_take,
  output logic                   cmd_release,
  output logic                   last_beat_take
);

  localparam int LANE_IDX_W = $clog2(`WDMA_LANES);

  logic [`WDMA_SIZE_W-1:0] beat_cnt;
  logic [`WDMA_LANES-1:0]  lane_onehot;
  logic                    lane_pvld;
  logic                    is_last_beat;
  logic                    cmd_take;
  logic                    dat_rdy;
  logic                    dat_take;

  // ==============================
  // lane select
  // ==============================

  // beat n reads lane n mod 4
  assign lane_onehot = `WDMA_LANES'(1) << beat_cnt[LANE_IDX_W-1:0];
  // no lane during the command packet
  assign lane_sel    = cmd_phase ? '0 : lane_onehot;
  assign lane_pvld   = |(lane_sel & dfifo_rd_pvld);

  // last beat when the count reaches size
  assign is_last_beat = (beat_cnt == cmd.size);

  // ==============================
  // handshakes
  // ==============================

  // command packet, then data beats
  assign beat_vld = cmd_phase ? cmd_held : lane_pvld;
  assign cmd_take = cmd_phase & cmd_held & dma_rdy;
  assign dat_rdy  = ~cmd_phase & dma_rdy;

  // ready only on the selected lane
  assign dfifo_rd_prdy = lane_sel & {`WDMA_LANES{dat_rdy}};
  assign lane_take     = dfifo_rd_prdy & dfifo_rd_pvld;
  assign dat_take      = |lane_take;

  assign last_beat_take = dat_take & is_last_beat;
  // frees the latch in the same cycle
  assign cmd_release    = last_beat_take;

  // ==============================
  // phase and beat count
  // ==============================

  // command phase out of reset
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cmd_phase <= 1'b1;
    end else if (cmd_take) begin
      cmd_phase <= 1'b0;
    end else if (last_beat_take) begin
      cmd_phase <= 1'b1;
    end
  end

  // restarts at lane 0 for every command
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      beat_cnt <= '0;
    end else if (last_beat_take) begin
      beat_cnt <= '0;
    end else if (dat_take) begin
      beat_cnt <= beat_cnt + `WDMA_SIZE_W'(1);
    end
  end

  // ==============================
  // checks
  // ==============================

  // stalled offer keeps its phase and lane until the port takes it
  stall_holds_offer: assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    (beat_vld && !dma_rdy) |=> (beat_vld && $stable(cmd_phase) && $stable(lane_sel))
  );

  // latch keeps the command until the last beat, so size stays valid
  beat_within_size: assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !cmd_phase |-> (cmd_held && beat_cnt <= cmd.size)
  );

endmodule

`default_nettype wire

//--- design/wdma_cfg_pkg.sv
// write dma register config
`default_nettype none

package wdma_cfg_pkg;

  // ==============================
  // element-wise alu operation
  // ==============================

  // eql drives the compare-only mode
  typedef enum logic [1:0] {
    EW_ALU_MAX = 2'd0,
    EW_ALU_MIN = 2'd1,
    EW_ALU_SUM = 2'd2,
    EW_ALU_EQL = 2'd3
  } ew_alu_op_e;

  // ==============================
  // static layer config
  // ==============================

  // sampled from the register file, static within a layer
  typedef struct packed {
    // 1 = result goes to the pooling engine
    logic       output_dst;
    // whole element-wise unit bypassed
    logic       ew_bypass;
    // alu stage inside the element-wise unit bypassed
    logic       ew_alu_bypass;
    ew_alu_op_e ew_alu_algo;
    // which interrupt line the done event goes to
    logic       interrupt_ptr;
  } wdma_cfg_t;

endpackage

`default_nettype wire

//--- design/wdma_cmd_latch.sv
// write dma command latch
`timescale 1ns/1ps
`default_nettype none

`include "wdma_defines.svh"

module wdma_cmd_latch import wdma_pkt_pkg::*; (
  input  logic      autosa_core_clk,
  input  logic      autosa_core_rstn,
  // command in
  input  wdma_cmd_t cmd_pd,
  input  logic      cmd_pvld,
  output logic      cmd_prdy,
  // last data beat of the held command accepted
  input  logic      cmd_release,
  // held command out
  output logic      cmd_held,
  output wdma_cmd_t cmd
);

  logic cmd_take;

  // ==============================
  // accept side
  // ==============================

  // free slot, or slot freeing up this cycle
  assign cmd_prdy = ~cmd_held | cmd_release;
  assign cmd_take = cmd_pvld & cmd_prdy;

  // held flag
  // reloads on release so back-to-back commands leave no bubble
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cmd_held <= 1'b0;
    end else if (cmd_prdy) begin
      cmd_held <= cmd_pvld;
    end
  end

  // command fields, only meaningful while held
  always_ff @(posedge autosa_core_clk) begin
    if (cmd_take) begin
      cmd <= cmd_pd;
    end
  end

  // ==============================
  // checks
  // ==============================

  // sequencer only releases a command it is working on
  release_needs_held: assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    cmd_release |-> cmd_held
  );

endmodule

`default_nettype wire

//--- design/wdma_dat_out.sv
// write dma data output stage
`timescale 1ns/1ps
`default_nettype none

`include "wdma_defines.svh"

module wdma_dat_out import wdma_cfg_pkg::*, wdma_pkt_pkg::*; (
  input  logic                   autosa_core_clk,
  input  logic                   autosa_core_rstn,
  // layer control
  input  logic                   op_load,
  input  wdma_cfg_t              cfg,
  // command in
  input  wdma_cmd_t              cmd_pd,
  input  logic                   cmd_pvld,
  output logic                   cmd_prdy,
  // data fifo lanes
  input  wdma_lanes_t            dfifo_rd_pd,
  input  logic [`WDMA_LANES-1:0] dfifo_rd_pvld,
  output logic [`WDMA_LANES-1:0] dfifo_rd_prdy,
  // write request port
  output wdma_req_t              dma_wr_req_pd,
  output logic                   dma_wr_req_vld,
  input  logic                   dma_wr_req_rdy,
  // status and interrupt
  output logic                   dp2reg_done,
  output logic                   dp2reg_status_unequal,
  output logic                   intr_req_ptr,
  output logic                   intr_req_pvld
);

  // latch to the rest
  logic                   cmd_held;
  wdma_cmd_t              cmd;
  // sequencer control
  logic                   cmd_release;
  logic                   cmd_phase;
  logic [`WDMA_LANES-1:0] lane_sel;
  logic                   beat_vld;
  logic [`WDMA_LANES-1:0] lane_take;
  logic                   last_beat_take;
  // packer back to sequencer
  logic                   dma_rdy;

  // ==============================
  // command input
  // ==============================

  wdma_cmd_latch u_cmd_latch (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .cmd_pd           (cmd_pd),
    .cmd_pvld         (cmd_pvld),
    .cmd_prdy         (cmd_prdy),
    .cmd_release      (cmd_release),
    .cmd_held         (cmd_held),
    .cmd              (cmd)
  );

  // ==============================
  // beat control
  // ==============================

  wdma_beat_sequencer u_beat_sequencer (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .cmd_held         (cmd_held),
    .cmd              (cmd),
    .dma_rdy          (dma_rdy),
    .dfifo_rd_pvld    (dfifo_rd_pvld),
    .dfifo_rd_prdy    (dfifo_rd_prdy),
    .cmd_phase        (cmd_phase),
    .lane_sel         (lane_sel),
    .beat_vld         (beat_vld),
    .lane_take        (lane_take),
    .cmd_release      (cmd_release),
    .last_beat_take   (last_beat_take)
  );

  // ==============================
  // request out
  // ==============================

  wdma_req_packer u_req_packer (
    .cfg            (cfg),
    .dma_wr_req_rdy (dma_wr_req_rdy),
    .dma_rdy        (dma_rdy),
    .cmd            (cmd),
    .cmd_phase      (cmd_phase),
    .lane_sel       (lane_sel),
    .beat_vld       (beat_vld),
    .dfifo_rd_pd    (dfifo_rd_pd),
    .dma_wr_req_pd  (dma_wr_req_pd),
    .dma_wr_req_vld (dma_wr_req_vld)
  );

  // status, done and interrupt
  wdma_eq_status u_eq_status (
    .autosa_core_clk       (autosa_core_clk),
    .autosa_core_rstn      (autosa_core_rstn),
    .op_load               (op_load),
    .cfg                   (cfg),
    .dfifo_rd_pd           (dfifo_rd_pd),
    .lane_take             (lane_take),
    .last_beat_take        (last_beat_take),
    .cmd                   (cmd),
    .dp2reg_status_unequal (dp2reg_status_unequal),
    .dp2reg_done           (dp2reg_done),
    .intr_req_ptr          (intr_req_ptr),
    .intr_req_pvld         (intr_req_pvld)
  );

endmodule

`default_nettype wire

//--- design/wdma_defines.svh
// write dma output widths
`ifndef WDMA_DEFINES_SVH
`define WDMA_DEFINES_SVH

// ==============================
// address widths
// ==============================

// line address, counted in 32-byte lines
`define WDMA_ADDR_W 59

// line to byte address shift
`define WDMA_LINE_SHIFT 5

// byte address on the request port
`define WDMA_BYTE_ADDR_W 64

// ==============================
// transfer sizing
// ==============================

// beat count minus one
`define WDMA_SIZE_W 13

// one fifo atom, 32 bytes
`define WDMA_ATOM_W 256

// data fifo lanes, read round robin
`define WDMA_LANES 4

// ==============================
// request port
// ==============================

// full request packet, is_data flag on top
`define WDMA_REQ_W 258

// used bits of a command packet
// byte addr + size + require_ack
`define WDMA_CMD_PKT_W 78

`endif

//--- design/wdma_eq_status.sv
// write dma status and interrupt
`timescale 1ns/1ps
`default_nettype none

`include "wdma_defines.svh"

module wdma_eq_status import wdma_cfg_pkg::*, wdma_pkt_pkg::*; (
  input  logic                   autosa_core_clk,
  input  logic                   autosa_core_rstn,
  // layer start, clears the status
  input  logic                   op_load,
  input  wdma_cfg_t              cfg,
  // consumed atoms
  input  wdma_lanes_t            dfifo_rd_pd,
  input  logic [`WDMA_LANES-1:0] lane_take,
  input  logic                   last_beat_take,
  input  wdma_cmd_t              cmd,
  // register and interrupt outputs
  output logic                   dp2reg_status_unequal,
  output logic                   dp2reg_done,
  output logic                   intr_req_ptr,
  output logic                   intr_req_pvld
);

  logic [`WDMA_LANES-1:0] lane_unequal;
  logic                   layer_done;

  // ==============================
  // unequal status
  // ==============================

  // sticky per lane, any nonzero bit in a taken atom
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      lane_unequal <= '0;
    end else if (op_load) begin
      lane_unequal <= '0;
    end else begin
      for (int i = 0; i < `WDMA_LANES; i++) begin
        if (lane_take[i]) begin
          lane_unequal[i] <= lane_unequal[i] | (|dfifo_rd_pd[i]);
        end
      end
    end
  end

  assign dp2reg_status_unequal = |lane_unequal;

  // ==============================
  // done and interrupt
  // ==============================

  // last beat of the cube
  assign layer_done = last_beat_take & cmd.cube_end;

  assign intr_req_pvld = layer_done;
  assign intr_req_ptr  = cfg.interrupt_ptr;

  // done flag one cycle after the interrupt
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      dp2reg_done <= 1'b0;
    end else begin
      dp2reg_done <= layer_done;
    end
  end

  // the sequencer reads one lane at a time
  single_lane_take: assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    $onehot0(lane_take)
  );

endmodule

`default_nettype wire

//--- design/wdma_pkt_pkg.sv
// write dma packet types
`default_nettype none

`include "wdma_defines.svh"

package wdma_pkt_pkg;

  // ==============================
  // command from the cmd splitter
  // ==============================

  typedef struct packed {
    // last command of the output cube
    logic                    cube_end;
    // beats minus one
    logic [`WDMA_SIZE_W-1:0] size;
    // line address
    logic [`WDMA_ADDR_W-1:0] addr;
  } wdma_cmd_t;

  // one atom per data fifo, lane 0 in the low slot
  typedef logic [`WDMA_LANES-1:0][`WDMA_ATOM_W-1:0] wdma_lanes_t;

  // ==============================
  // write request packet
  // ==============================

  // command body, zero padded up to the body width
  typedef struct packed {
    logic [`WDMA_REQ_W-2-`WDMA_CMD_PKT_W:0] pad;
    logic                                   require_ack;
    logic [`WDMA_SIZE_W-1:0]                size;
    logic [`WDMA_BYTE_ADDR_W-1:0]           addr;
  } wdma_req_cmd_t;

  // data body, single atom per beat
  typedef struct packed {
    logic                    mask;
    logic [`WDMA_ATOM_W-1:0] data;
  } wdma_req_dat_t;

  // is_data selects which body layout applies
  typedef struct packed {
    logic                  is_data;
    logic [`WDMA_REQ_W-2:0] body;
  } wdma_req_t;

endpackage

`default_nettype wire

//--- design/wdma_req_packer.sv
// write dma request packer
`timescale 1ns/1ps
`default_nettype none

`include "wdma_defines.svh"

module wdma_req_packer import wdma_cfg_pkg::*, wdma_pkt_pkg::*; (
  input  wdma_cfg_t              cfg,
  // request port ready, and its quiet-mode version
  input  logic                   dma_wr_req_rdy,
  output logic                   dma_rdy,
  // from the latch and the sequencer
  input  wdma_cmd_t              cmd,
  input  logic                   cmd_phase,
  input  logic [`WDMA_LANES-1:0] lane_sel,
  input  logic                   beat_vld,
  input  wdma_lanes_t            dfifo_rd_pd,
  // request port
  output wdma_req_t              dma_wr_req_pd,
  output logic                   dma_wr_req_vld
);

  logic                    mode_eql;
  logic                    mode_pdp;
  logic                    mode_quiet;
  logic [`WDMA_ATOM_W-1:0] sel_atom;
  wdma_req_cmd_t           cmd_body;
  wdma_req_dat_t           dat_body;

  // ==============================
  // quiet mode decode
  // ==============================

  // compare-only run, alu live and set to eql
  assign mode_eql   = ~cfg.ew_bypass & ~cfg.ew_alu_bypass & (cfg.ew_alu_algo == EW_ALU_EQL);
  // result goes to pooling, not memory
  assign mode_pdp   = cfg.output_dst;
  assign mode_quiet = mode_eql | mode_pdp;

  // quiet mode drains everything without the port
  assign dma_rdy        = mode_quiet | dma_wr_req_rdy;
  assign dma_wr_req_vld = beat_vld & ~mode_quiet;

  // ==============================
  // packet build
  // ==============================

  // one-hot atom mux
  always_comb begin
    sel_atom = '0;
    for (int i = 0; i < `WDMA_LANES; i++) begin
      if (lane_sel[i]) begin
        sel_atom = sel_atom | dfifo_rd_pd[i];
      end
    end
  end

  // line address to bytes, ack only on the cube end
  assign cmd_body.pad         = '0;
  assign cmd_body.require_ack = cmd.cube_end;
  assign cmd_body.size        = cmd.size;
  assign cmd_body.addr        = {cmd.addr, {`WDMA_LINE_SHIFT{1'b0}}};

  // single atom per beat, mask always full
  assign dat_body.mask = 1'b1;
  assign dat_body.data = sel_atom;

  always_comb begin
    dma_wr_req_pd.is_data = ~cmd_phase;
    if (cmd_phase) begin
      dma_wr_req_pd.body = cmd_body;
    end else begin
      dma_wr_req_pd.body = dat_body;
    end
  end

endmodule

`default_nettype wire

//--- tests/wdma_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module wdma_clk_gen #(
  parameter real PERIOD_NS  = 4.0,
  parameter int  RST_CYCLES = 4
) (
  output logic autosa_core_clk,
  output logic autosa_core_rstn
);

  // free running clock
  initial begin
    autosa_core_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) autosa_core_clk = ~autosa_core_clk;
    end
  end

  // reset held a few cycles, released on a falling edge
  initial begin
    autosa_core_rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge autosa_core_clk);
    @(negedge autosa_core_clk);
    autosa_core_rstn = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/wdma_dat_out_tb.sv
// write dma output stage testbench
`timescale 1ns/1ps
`default_nettype none

`include "wdma_defines.svh"

module wdma_dat_out_tb import wdma_cfg_pkg::*, wdma_pkt_pkg::*; ();

  localparam int unsigned SEED           = 32'h1a71;
  localparam int          CMDS_PER_RUN   = 12;
  localparam int          NUM_RUNS       = 4;
  localparam int          MAX_SIZE       = 20;
  // command packet plus the longest burst
  localparam int          MAX_BEATS      = MAX_SIZE + 2;
  localparam real         CLK_PERIOD_NS  = 4.0;
  localparam int          TIMEOUT_CYCLES = NUM_RUNS * CMDS_PER_RUN * MAX_BEATS * 40;

  logic                    autosa_core_clk;
  logic                    autosa_core_rstn;
  // dut inputs
  logic                    op_load;
  wdma_cfg_t               cfg;
  wdma_cmd_t               cmd_pd;
  logic                    cmd_pvld;
  wdma_lanes_t             dfifo_rd_pd;
  logic [`WDMA_LANES-1:0]  dfifo_rd_pvld;
  logic                    dma_wr_req_rdy;
  // dut outputs
  logic                    cmd_prdy;
  logic [`WDMA_LANES-1:0]  dfifo_rd_prdy;
  wdma_req_t               dma_wr_req_pd;
  logic                    dma_wr_req_vld;
  logic                    dp2reg_done;
  logic                    dp2reg_status_unequal;
  logic                    intr_req_ptr;
  logic                    intr_req_pvld;

  // ==============================
  // model state
  // ==============================

  // commands not yet offered, and accepted but not finished
  wdma_cmd_t               cmd_src_q[$];
  wdma_cmd_t               cmd_acc_q[$];
  // per lane fifo contents
  logic [`WDMA_ATOM_W-1:0] lane_q[`WDMA_LANES][$];
  // predicted request packets, in port order
  wdma_req_t               exp_q[$];
  logic                    cmd_busy;
  logic [`WDMA_LANES-1:0]  lane_busy;
  int                      exp_beat;
  logic                    exp_unequal;
  logic                    exp_done;
  logic                    hold_pending;
  wdma_req_t               held_pd;
  wdma_cfg_t               next_cfg;
  logic                    load_req;
  logic                    quiet;

  wdma_clk_gen #(
    .PERIOD_NS  (CLK_PERIOD_NS),
    .RST_CYCLES (4)
  ) u_clk_gen (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn)
  );

  wdma_dat_out wdma_dat_out_inst (
    .autosa_core_clk       (autosa_core_clk),
    .autosa_core_rstn      (autosa_core_rstn),
    .op_load               (op_load),
    .cfg                   (cfg),
    .cmd_pd                (cmd_pd),
    .cmd_pvld              (cmd_pvld),
    .cmd_prdy              (cmd_prdy),
    .dfifo_rd_pd           (dfifo_rd_pd),
    .dfifo_rd_pvld         (dfifo_rd_pvld),
    .dfifo_rd_prdy         (dfifo_rd_prdy),
    .dma_wr_req_pd         (dma_wr_req_pd),
    .dma_wr_req_vld        (dma_wr_req_vld),
    .dma_wr_req_rdy        (dma_wr_req_rdy),
    .dp2reg_done           (dp2reg_done),
    .dp2reg_status_unequal (dp2reg_status_unequal),
    .intr_req_ptr          (intr_req_ptr),
    .intr_req_pvld         (intr_req_pvld)
  );

  task automatic check(input string name, input logic [`WDMA_REQ_W-1:0] got,
                       input logic [`WDMA_REQ_W-1:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic wdma_cfg_t make_cfg(input logic dst, input logic ew_byp,
                                         input logic alu_byp, input ew_alu_op_e algo,
                                         input logic ptr);
    wdma_cfg_t c;
    c.output_dst    = dst;
    c.ew_bypass     = ew_byp;
    c.ew_alu_bypass = alu_byp;
    c.ew_alu_algo   = algo;
    c.interrupt_ptr = ptr;
    return c;
  endfunction

  // about a third of the atoms are all zero
  function automatic logic [`WDMA_ATOM_W-1:0] rand_atom(input bit zero_only);
    logic [`WDMA_ATOM_W-1:0] atom;
    atom = '0;
    if (!zero_only && ($urandom % 3 != 0)) begin
      for (int w = 0; w < `WDMA_ATOM_W / 32; w++) begin
        atom[w*32 +: 32] = $urandom;
      end
    end
    return atom;
  endfunction

  // line address in 32-byte units, ack only on the cube end
  function automatic wdma_req_t cmd_packet(input wdma_cmd_t c);
    wdma_req_t                    pkt;
    logic [`WDMA_BYTE_ADDR_W-1:0] byte_addr;
    byte_addr   = `WDMA_BYTE_ADDR_W'(c.addr) * 32;
    pkt.is_data = 1'b0;
    pkt.body    = {{(`WDMA_REQ_W-1-`WDMA_CMD_PKT_W){1'b0}}, c.cube_end, c.size, byte_addr};
    return pkt;
  endfunction

  function automatic wdma_req_t data_packet(input logic [`WDMA_ATOM_W-1:0] atom);
    wdma_req_t pkt;
    pkt.is_data = 1'b1;
    pkt.body    = {1'b1, atom};
    return pkt;
  endfunction

  function automatic bit lanes_pending();
    bit any;
    any = 1'b0;
    for (int i = 0; i < `WDMA_LANES; i++) begin
      any = any | (lane_q[i].size() != 0);
    end
    return any;
  endfunction

  // ==============================
  // stimulus generation
  // ==============================

  // beat b of every command comes from lane b mod 4
  task automatic load_cmds(input bit zero_only, output bit any_nonzero);
    wdma_cmd_t               c;
    logic [`WDMA_ATOM_W-1:0] atom;
    any_nonzero = 1'b0;
    for (int n = 0; n < CMDS_PER_RUN; n++) begin
      c.addr     = `WDMA_ADDR_W'({$urandom, $urandom});
      c.size     = `WDMA_SIZE_W'($urandom % (MAX_SIZE + 1));
      c.cube_end = 1'($urandom % 2);
      cmd_src_q.push_back(c);
      if (!quiet) begin
        exp_q.push_back(cmd_packet(c));
      end
      for (int b = 0; b <= int'(c.size); b++) begin
        atom = rand_atom(zero_only);
        lane_q[b % `WDMA_LANES].push_back(atom);
        any_nonzero = any_nonzero | (atom != '0);
        if (!quiet) begin
          exp_q.push_back(data_packet(atom));
        end
      end
    end
  endtask

  // one clock: drive on the falling edge, check on the rising edge
  task automatic step();
    logic [`WDMA_LANES-1:0]  take_vec;
    logic [`WDMA_LANES-1:0]  exp_take;
    logic [`WDMA_ATOM_W-1:0] atom;
    logic                    exp_intr;
    logic                    exp_prdy;
    logic                    nonzero_take;
    int                      lane;
    wdma_req_t               exp_pkt;

    @(negedge autosa_core_clk);
    cfg      = next_cfg;
    op_load  = load_req;
    load_req = 1'b0;
    // command held until taken
    if (!cmd_busy && cmd_src_q.size() != 0 && ($urandom % 4 != 0)) begin
      cmd_busy = 1'b1;
      cmd_pd   = cmd_src_q.pop_front();
    end
    cmd_pvld = cmd_busy;
    // random valid gaps per lane, front atom held once valid
    for (int i = 0; i < `WDMA_LANES; i++) begin
      if (!lane_busy[i] && lane_q[i].size() != 0 && ($urandom % 4 != 0)) begin
        lane_busy[i] = 1'b1;
      end
      dfifo_rd_pvld[i] = lane_busy[i];
      dfifo_rd_pd[i]   = lane_busy[i] ? lane_q[i][0] : '0;
    end
    dma_wr_req_rdy = ($urandom % 3 != 0);

    @(posedge autosa_core_clk);
    if (quiet) begin
      check("dma_wr_req_vld", dma_wr_req_vld, 1'b0);
    end
    // stalled packet stays put
    if (hold_pending) begin
      check("dma_wr_req_vld", dma_wr_req_vld, 1'b1);
      check("dma_wr_req_pd", dma_wr_req_pd, held_pd);
    end
    if (dma_wr_req_vld && dma_wr_req_rdy) begin
      // extra packet beyond the prediction
      if (exp_q.size() == 0) begin
        check("dma_wr_req_vld", 1'b1, 1'b0);
      end
      exp_pkt = exp_q.pop_front();
      check("dma_wr_req_pd", dma_wr_req_pd, exp_pkt);
    end
    hold_pending = dma_wr_req_vld && !dma_wr_req_rdy;
    held_pd      = dma_wr_req_pd;

    check("dp2reg_status_unequal", dp2reg_status_unequal, exp_unequal);
    check("dp2reg_done", dp2reg_done, exp_done);

    take_vec     = dfifo_rd_pvld & dfifo_rd_prdy;
    exp_intr     = 1'b0;
    // latch free when no command is in flight
    exp_prdy     = (cmd_acc_q.size() == 0);
    nonzero_take = 1'b0;
    if (take_vec != '0) begin
      // no fifo read without a command
      if (cmd_acc_q.size() == 0) begin
        check("dfifo_rd_prdy", take_vec, '0);
      end
      lane     = exp_beat % `WDMA_LANES;
      exp_take = `WDMA_LANES'(1) << lane;
      check("dfifo_rd_prdy", take_vec, exp_take);
      atom            = lane_q[lane].pop_front();
      lane_busy[lane] = 1'b0;
      nonzero_take    = (atom != '0);
      // last beat closes the command
      if (exp_beat == int'(cmd_acc_q[0].size)) begin
        exp_intr = cmd_acc_q[0].cube_end;
        // next command may enter in the release cycle
        exp_prdy = 1'b1;
        void'(cmd_acc_q.pop_front());
        exp_beat = 0;
      end else begin
        exp_beat++;
      end
    end
    check("cmd_prdy", cmd_prdy, exp_prdy);
    check("intr_req_pvld", intr_req_pvld, exp_intr);
    if (exp_intr) begin
      check("intr_req_ptr", intr_req_ptr, cfg.interrupt_ptr);
    end
    exp_done = exp_intr;
    // clear wins over a take in the same cycle
    if (op_load) begin
      exp_unequal = 1'b0;
    end else if (nonzero_take) begin
      exp_unequal = 1'b1;
    end
    if (cmd_pvld && cmd_prdy) begin
      cmd_acc_q.push_back(cmd_pd);
      cmd_busy = 1'b0;
    end
  endtask

  // one layer: op_load, a batch of commands, drain
  task automatic run_cfg(input wdma_cfg_t c, input bit quiet_mode, input bit zero_only);
    bit any_nonzero;
    next_cfg = c;
    quiet    = quiet_mode;
    load_req = 1'b1;
    load_cmds(zero_only, any_nonzero);
    while (cmd_src_q.size() != 0 || cmd_busy || cmd_acc_q.size() != 0 ||
           lanes_pending() || exp_q.size() != 0) begin
      step();
    end
    // done pulse and status register settle
    repeat (3) step();
    check("dp2reg_status_unequal", dp2reg_status_unequal, any_nonzero);
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    op_load        = 1'b0;
    cfg            = '0;
    cmd_pd         = '0;
    cmd_pvld       = 1'b0;
    dfifo_rd_pd    = '0;
    dfifo_rd_pvld  = '0;
    dma_wr_req_rdy = 1'b0;
    cmd_busy       = 1'b0;
    lane_busy      = '0;
    exp_beat       = 0;
    exp_unequal    = 1'b0;
    exp_done       = 1'b0;
    hold_pending   = 1'b0;
    held_pd        = '0;
    next_cfg       = '0;
    load_req       = 1'b0;
    quiet          = 1'b0;
    void'($urandom(SEED));

    // outputs while reset is held
    @(negedge autosa_core_clk);
    check("cmd_prdy", cmd_prdy, 1'b1);
    check("dma_wr_req_vld", dma_wr_req_vld, 1'b0);
    check("dfifo_rd_prdy", dfifo_rd_prdy, '0);
    check("dp2reg_done", dp2reg_done, 1'b0);
    check("intr_req_pvld", intr_req_pvld, 1'b0);
    wait (autosa_core_rstn === 1'b1);

    // normal write out, mixed atoms
    run_cfg(make_cfg(1'b0, 1'b0, 1'b0, EW_ALU_SUM, 1'b1), 1'b0, 1'b0);
    // eql with the unit bypassed still writes, zero atoms only
    run_cfg(make_cfg(1'b0, 1'b1, 1'b0, EW_ALU_EQL, 1'b0), 1'b0, 1'b1);
    // equal-compare run, port silent
    run_cfg(make_cfg(1'b0, 1'b0, 1'b0, EW_ALU_EQL, 1'($urandom % 2)), 1'b1, 1'b0);
    // output to pooling, port silent
    run_cfg(make_cfg(1'b1, 1'b0, 1'b0, EW_ALU_MAX, 1'b1), 1'b1, 1'b0);

    $display("ALL CHECKS PASSED");
    $finish;
  end

  // watchdog, sized from the longest possible run
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
    $display("watchdog timeout after %0d cycles, the DUT stopped draining", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire
